// ==== mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// physical byte address
`define MEM_ADDR_W 32

// one AXI beat, a full double word
`define MEM_DATA_W 64

// one enable per byte lane
`define MEM_STRB_W (`MEM_DATA_W / 8)

// AXI transaction id, always driven as zero
`define MEM_ID_W 4

`endif

// ==== mem_pkg.sv ====
`include "mem_cfg.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_W-1:0] addr_t;
    typedef logic [`MEM_DATA_W-1:0] dword_t;
    typedef logic [`MEM_STRB_W-1:0] strb_t;
    typedef logic [31:0]            instr_t;

    typedef enum logic [1:0] {
        SIZE_B = 2'b00, // funct3[1:0] encoding
        SIZE_H = 2'b01,
        SIZE_W = 2'b10,
        SIZE_D = 2'b11
    } size_e;

    typedef struct packed {
        addr_t  addr;  // double-word aligned
        logic   we;
        dword_t wdata; // already in its lanes
        strb_t  strb;
    } bus_req_t;

    typedef struct packed {
        dword_t rdata;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_LSU
    } arb_state_e;

    typedef enum logic [1:0] {
        AXI_IDLE,
        AXI_ADDR,
        AXI_DATA, // r channel
        AXI_RESP  // b channel
    } axi_state_e;

    typedef struct packed {
        addr_t                addr;
        logic [`MEM_ID_W-1:0] id;
    } axi_ar_t;

    typedef struct packed {
        addr_t                addr;
        logic [`MEM_ID_W-1:0] id;
    } axi_aw_t;

    typedef struct packed {
        dword_t data;
        strb_t  strb;
    } axi_w_t;

endpackage

// ==== fetch_port.sv ====
`timescale 1ns/1ps

module fetch_port (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              fetch_req_i,
    input  mem_pkg::addr_t    fetch_addr_i,
    output logic              fetch_busy_o,
    output logic              fetch_valid_o,
    output mem_pkg::instr_t   fetch_instr_o,
    output logic              bus_req_o,
    output mem_pkg::bus_req_t bus_req_data_o,
    input  logic              bus_done_i,
    input  mem_pkg::bus_rsp_t bus_rsp_i
);
    import mem_pkg::*;

    logic  busy_q;
    addr_t addr_q;
    logic  accept;

    assign accept = fetch_req_i && !busy_q; // strobes while busy are dropped

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q        <= 1'b0;
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= busy_q && bus_done_i;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (bus_done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= fetch_addr_i;
        end
        if (busy_q && bus_done_i) begin
            // bit 2 picks the instruction half of the double word
            fetch_instr_o <= addr_q[2] ? bus_rsp_i.rdata[63:32] : bus_rsp_i.rdata[31:0];
        end
    end

    assign fetch_busy_o = busy_q;
    assign bus_req_o    = busy_q; // request level held until done

    assign bus_req_data_o = '{
        addr:  {addr_q[$bits(addr_t)-1:3], 3'b000},
        we:    1'b0,
        wdata: '0,
        strb:  '1
    };

endmodule

// ==== lsu_port.sv ====
`timescale 1ns/1ps

module lsu_port (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              lsu_req_i,
    input  logic              lsu_we_i,
    input  mem_pkg::size_e    lsu_size_i,
    input  logic              lsu_unsigned_i,
    input  mem_pkg::addr_t    lsu_addr_i,
    input  mem_pkg::dword_t   lsu_wdata_i,
    output logic              lsu_busy_o,
    output logic              lsu_done_o,
    output mem_pkg::dword_t   lsu_rdata_o,
    output logic              bus_req_o,
    output mem_pkg::bus_req_t bus_req_data_o,
    input  logic              bus_done_i,
    input  mem_pkg::bus_rsp_t bus_rsp_i
);
    import mem_pkg::*;

    logic     busy_q;
    logic     accept;
    size_e    size_q;
    logic     unsigned_q;
    logic     [2:0] off_q;
    bus_req_t req_q;
    strb_t    strb_d;
    dword_t   lanes;
    dword_t   load_ext;

    assign accept = lsu_req_i && !busy_q;

    always_comb begin
        case (lsu_size_i)
            SIZE_B:  strb_d = strb_t'(8'h01) << lsu_addr_i[2:0];
            SIZE_H:  strb_d = strb_t'(8'h03) << lsu_addr_i[2:0];
            SIZE_W:  strb_d = strb_t'(8'h0f) << lsu_addr_i[2:0];
            default: strb_d = '1;
        endcase
    end

    always_comb begin
        lanes = bus_rsp_i.rdata >> {off_q, 3'b000}; // bring the addressed lane to bit 0
        case (size_q)
            SIZE_B:  load_ext = {{56{lanes[7] & ~unsigned_q}}, lanes[7:0]};
            SIZE_H:  load_ext = {{48{lanes[15] & ~unsigned_q}}, lanes[15:0]};
            SIZE_W:  load_ext = {{32{lanes[31] & ~unsigned_q}}, lanes[31:0]};
            default: load_ext = lanes;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q     <= 1'b0;
            lsu_done_o <= 1'b0;
        end else begin
            lsu_done_o <= busy_q && bus_done_i;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (bus_done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            size_q      <= lsu_size_i;
            unsigned_q  <= lsu_unsigned_i;
            off_q       <= lsu_addr_i[2:0];
            req_q.addr  <= {lsu_addr_i[$bits(addr_t)-1:3], 3'b000};
            req_q.we    <= lsu_we_i;
            req_q.wdata <= lsu_wdata_i << {lsu_addr_i[2:0], 3'b000};
            req_q.strb  <= strb_d;
        end
        if (busy_q && bus_done_i) begin
            lsu_rdata_o <= req_q.we ? '0 : load_ext; // stores return zero
        end
    end

    assign lsu_busy_o     = busy_q;
    assign bus_req_o      = busy_q;
    assign bus_req_data_o = req_q;

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              fetch_req_i,
    input  mem_pkg::bus_req_t fetch_req_data_i,
    output logic              fetch_done_o,
    input  logic              lsu_req_i,
    input  mem_pkg::bus_req_t lsu_req_data_i,
    output logic              lsu_done_o,
    output mem_pkg::bus_rsp_t rsp_o,
    output logic              start_o,
    output mem_pkg::bus_req_t req_data_o,
    input  logic              done_i,
    input  mem_pkg::bus_rsp_t rsp_i
);
    import mem_pkg::*;

    arb_state_e state_q;
    logic       sel_lsu;

    // in idle the load/store side wins a tie
    assign sel_lsu = (state_q == ARB_LSU) || (state_q == ARB_IDLE && lsu_req_i);

    assign start_o    = (state_q == ARB_IDLE) && (fetch_req_i || lsu_req_i);
    assign req_data_o = sel_lsu ? lsu_req_data_i : fetch_req_data_i;

    assign fetch_done_o = done_i && (state_q == ARB_FETCH); // done goes to the owner only
    assign lsu_done_o   = done_i && (state_q == ARB_LSU);
    assign rsp_o        = rsp_i;                            // shared by both ports

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ARB_IDLE;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (lsu_req_i) begin
                        state_q <= ARB_LSU;
                    end else if (fetch_req_i) begin
                        state_q <= ARB_FETCH;
                    end
                end
                ARB_FETCH, ARB_LSU: begin
                    if (done_i) begin
                        state_q <= ARB_IDLE; // grant held for the whole access
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

endmodule

// ==== axi_master.sv ====
`timescale 1ns/1ps

module axi_master (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  mem_pkg::bus_req_t req_i,
    output logic              done_o,
    output mem_pkg::bus_rsp_t rsp_o,
    output logic              axi_aw_valid_o,
    input  logic              axi_aw_ready_i,
    output mem_pkg::axi_aw_t  axi_aw_o,
    output logic              axi_w_valid_o,
    input  logic              axi_w_ready_i,
    output mem_pkg::axi_w_t   axi_w_o,
    output logic              axi_w_last_o,
    input  logic              axi_b_valid_i,
    output logic              axi_b_ready_o,
    output logic              axi_ar_valid_o,
    input  logic              axi_ar_ready_i,
    output mem_pkg::axi_ar_t  axi_ar_o,
    input  logic              axi_r_valid_i,
    output logic              axi_r_ready_o,
    input  mem_pkg::dword_t   axi_r_data_i
);
    import mem_pkg::*;

    axi_state_e state_q;
    bus_req_t   req_q;
    logic       aw_done_q;
    logic       w_done_q;
    logic       aw_hs;
    logic       w_hs;

    assign axi_aw_valid_o = (state_q == AXI_ADDR) && req_q.we && !aw_done_q;
    assign axi_w_valid_o  = (state_q == AXI_ADDR) && req_q.we && !w_done_q;
    assign axi_ar_valid_o = (state_q == AXI_ADDR) && !req_q.we;
    assign axi_r_ready_o  = (state_q == AXI_DATA);
    assign axi_b_ready_o  = (state_q == AXI_RESP);
    assign axi_w_last_o   = 1'b1; // single beat, always the last one

    // len 0, size 8 bytes, INCR and id 0; sideband fields are not exported
    assign axi_aw_o = '{addr: req_q.addr, id: '0};
    assign axi_ar_o = '{addr: req_q.addr, id: '0};
    assign axi_w_o  = '{data: req_q.wdata, strb: req_q.strb};

    assign aw_hs = axi_aw_valid_o && axi_aw_ready_i;
    assign w_hs  = axi_w_valid_o && axi_w_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= AXI_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                AXI_IDLE: begin
                    aw_done_q <= 1'b0;
                    w_done_q  <= 1'b0;
                    if (start_i) begin
                        state_q <= AXI_ADDR;
                    end
                end
                AXI_ADDR: begin
                    if (req_q.we) begin
                        if (aw_hs) begin
                            aw_done_q <= 1'b1; // aw and w may finish in any order
                        end
                        if (w_hs) begin
                            w_done_q <= 1'b1;
                        end
                        if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
                            state_q <= AXI_RESP;
                        end
                    end else if (axi_ar_ready_i) begin
                        state_q <= AXI_DATA;
                    end
                end
                AXI_DATA: begin
                    if (axi_r_valid_i) begin
                        state_q <= AXI_IDLE;
                        done_o  <= 1'b1;
                    end
                end
                AXI_RESP: begin
                    if (axi_b_valid_i) begin // response code ignored
                        state_q <= AXI_IDLE;
                        done_o  <= 1'b1;
                    end
                end
                default: state_q <= AXI_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == AXI_IDLE && start_i) begin
            req_q <= req_i;
        end
        if (axi_r_ready_o && axi_r_valid_i) begin
            rsp_o <= '{rdata: axi_r_data_i};
        end
    end

endmodule

// ==== cpu_mem_top.sv ====
`timescale 1ns/1ps

module cpu_mem_top (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             fetch_req_i,
    input  mem_pkg::addr_t   fetch_addr_i,
    output logic             fetch_busy_o,
    output logic             fetch_valid_o,
    output mem_pkg::instr_t  fetch_instr_o,
    input  logic             lsu_req_i,
    input  logic             lsu_we_i,
    input  mem_pkg::size_e   lsu_size_i,
    input  logic             lsu_unsigned_i,
    input  mem_pkg::addr_t   lsu_addr_i,
    input  mem_pkg::dword_t  lsu_wdata_i,
    output logic             lsu_busy_o,
    output logic             lsu_done_o,
    output mem_pkg::dword_t  lsu_rdata_o,
    output logic             axi_aw_valid_o,
    input  logic             axi_aw_ready_i,
    output mem_pkg::axi_aw_t axi_aw_o,
    output logic             axi_w_valid_o,
    input  logic             axi_w_ready_i,
    output mem_pkg::axi_w_t  axi_w_o,
    output logic             axi_w_last_o,
    input  logic             axi_b_valid_i,
    output logic             axi_b_ready_o,
    output logic             axi_ar_valid_o,
    input  logic             axi_ar_ready_i,
    output mem_pkg::axi_ar_t axi_ar_o,
    input  logic             axi_r_valid_i,
    output logic             axi_r_ready_o,
    input  mem_pkg::dword_t  axi_r_data_i
);
    import mem_pkg::*;

    logic     fetch_bus_req;
    bus_req_t fetch_bus_data;
    logic     fetch_bus_done;
    logic     lsu_bus_req;
    bus_req_t lsu_bus_data;
    logic     lsu_bus_done;
    bus_rsp_t port_rsp;   // fans out to both ports
    logic     axi_start;
    bus_req_t axi_req;
    logic     axi_done;
    bus_rsp_t axi_rsp;

    fetch_port fetch_port_inst (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .fetch_req_i    (fetch_req_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_busy_o   (fetch_busy_o),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_instr_o  (fetch_instr_o),
        .bus_req_o      (fetch_bus_req),
        .bus_req_data_o (fetch_bus_data),
        .bus_done_i     (fetch_bus_done),
        .bus_rsp_i      (port_rsp)
    );

    lsu_port lsu_port_inst (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .lsu_req_i      (lsu_req_i),
        .lsu_we_i       (lsu_we_i),
        .lsu_size_i     (lsu_size_i),
        .lsu_unsigned_i (lsu_unsigned_i),
        .lsu_addr_i     (lsu_addr_i),
        .lsu_wdata_i    (lsu_wdata_i),
        .lsu_busy_o     (lsu_busy_o),
        .lsu_done_o     (lsu_done_o),
        .lsu_rdata_o    (lsu_rdata_o),
        .bus_req_o      (lsu_bus_req),
        .bus_req_data_o (lsu_bus_data),
        .bus_done_i     (lsu_bus_done),
        .bus_rsp_i      (port_rsp)
    );

    mem_arbiter mem_arbiter_inst (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .fetch_req_i      (fetch_bus_req),
        .fetch_req_data_i (fetch_bus_data),
        .fetch_done_o     (fetch_bus_done),
        .lsu_req_i        (lsu_bus_req),
        .lsu_req_data_i   (lsu_bus_data),
        .lsu_done_o       (lsu_bus_done),
        .rsp_o            (port_rsp),
        .start_o          (axi_start),
        .req_data_o       (axi_req),
        .done_i           (axi_done),
        .rsp_i            (axi_rsp)
    );

    axi_master axi_master_inst (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .start_i        (axi_start),
        .req_i          (axi_req),
        .done_o         (axi_done),
        .rsp_o          (axi_rsp),
        .axi_aw_valid_o (axi_aw_valid_o),
        .axi_aw_ready_i (axi_aw_ready_i),
        .axi_aw_o       (axi_aw_o),
        .axi_w_valid_o  (axi_w_valid_o),
        .axi_w_ready_i  (axi_w_ready_i),
        .axi_w_o        (axi_w_o),
        .axi_w_last_o   (axi_w_last_o),
        .axi_b_valid_i  (axi_b_valid_i),
        .axi_b_ready_o  (axi_b_ready_o),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_ar_o       (axi_ar_o),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_ready_o  (axi_r_ready_o),
        .axi_r_data_i   (axi_r_data_i)
    );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o; // 100 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

// ==== cpu_mem_properties.sv ====
`timescale 1ns/1ps

module cpu_mem_properties (
    input logic                clk,
    input logic                arst_n_i,
    input logic                aw_valid_i,
    input logic                aw_ready_i,
    input mem_pkg::axi_aw_t    aw_i,
    input logic                w_valid_i,
    input logic                w_ready_i,
    input mem_pkg::axi_w_t     w_i,
    input logic                ar_valid_i,
    input logic                ar_ready_i,
    input mem_pkg::axi_ar_t    ar_i,
    input logic                start_i,
    input logic                done_i,
    input logic                fetch_req_i,
    input logic                lsu_req_i,
    input mem_pkg::arb_state_e arb_state_i
);
    import mem_pkg::*;

    logic outstanding_q;
    int   assert_errs = 0; // failed assertions, read by the testbench at the end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            outstanding_q <= 1'b0;
        end else if (start_i) begin
            outstanding_q <= 1'b1;
        end else if (done_i) begin
            outstanding_q <= 1'b0;
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
        else begin
            $error("aw valid or payload changed before ready");
            assert_errs++;
        end
    w_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
        else begin
            $error("w valid or payload changed before ready");
            assert_errs++;
        end
    ar_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
        else begin
            $error("ar valid or payload changed before ready");
            assert_errs++;
        end
    // the single owner keeps its request level until its done
    owner_requesting: assert property (@(posedge clk) disable iff (!arst_n_i)
        arb_state_i == ARB_IDLE
        || (arb_state_i == ARB_FETCH && fetch_req_i)
        || (arb_state_i == ARB_LSU && lsu_req_i))
        else begin
            $error("arbiter owned by a port that is not requesting");
            assert_errs++;
        end
    no_early_start: assert property (@(posedge clk) disable iff (!arst_n_i)
        start_i |-> !outstanding_q)
        else begin
            $error("start issued while a transaction is open");
            assert_errs++;
        end

endmodule

bind cpu_mem_top cpu_mem_properties cpu_mem_properties_inst (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .aw_valid_i  (axi_aw_valid_o),
    .aw_ready_i  (axi_aw_ready_i),
    .aw_i        (axi_aw_o),
    .w_valid_i   (axi_w_valid_o),
    .w_ready_i   (axi_w_ready_i),
    .w_i         (axi_w_o),
    .ar_valid_i  (axi_ar_valid_o),
    .ar_ready_i  (axi_ar_ready_i),
    .ar_i        (axi_ar_o),
    .start_i     (axi_start),
    .done_i      (axi_done),
    .fetch_req_i (fetch_bus_req),
    .lsu_req_i   (lsu_bus_req),
    .arb_state_i (mem_arbiter_inst.state_q)
);

// ==== tb_cpu_mem_top.sv ====
`timescale 1ns/1ps

module tb_cpu_mem_top;
    import mem_pkg::*;

    logic clk, arst_n;
    logic fetch_req, fetch_busy, fetch_valid;
    addr_t fetch_addr;
    instr_t fetch_instr;
    logic lsu_req, lsu_we, lsu_uns, lsu_busy, lsu_done;
    size_e lsu_size;
    addr_t lsu_addr;
    dword_t lsu_wdata, lsu_rdata;
    logic aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
    logic ar_valid, ar_ready, r_valid, r_ready;
    axi_aw_t aw;
    axi_w_t w;
    axi_ar_t ar;
    dword_t r_data;

    logic [7:0] mem [0:255];     // model memory, written over AXI
    logic [7:0] ref_mem [0:255]; // expected contents
    logic [15:0] lfsr = 16'd2;
    logic [1:0] ar_wait, aw_wait, w_wait;
    logic aw_seen, w_seen;
    addr_t wr_addr;
    axi_w_t wr_beat;
    int txn_count;
    int test_errs = 0, total_errs = 0, pass_count = 0, fail_count = 0;

    tb_clock tb_clock_inst (.clk_o(clk), .arst_n_o(arst_n));

    cpu_mem_top cpu_mem_top_inst (
        .clk(clk), .arst_n_i(arst_n),
        .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr), .fetch_busy_o(fetch_busy),
        .fetch_valid_o(fetch_valid), .fetch_instr_o(fetch_instr),
        .lsu_req_i(lsu_req), .lsu_we_i(lsu_we), .lsu_size_i(lsu_size),
        .lsu_unsigned_i(lsu_uns), .lsu_addr_i(lsu_addr), .lsu_wdata_i(lsu_wdata),
        .lsu_busy_o(lsu_busy), .lsu_done_o(lsu_done), .lsu_rdata_o(lsu_rdata),
        .axi_aw_valid_o(aw_valid), .axi_aw_ready_i(aw_ready), .axi_aw_o(aw),
        .axi_w_valid_o(w_valid), .axi_w_ready_i(w_ready), .axi_w_o(w), .axi_w_last_o(w_last),
        .axi_b_valid_i(b_valid), .axi_b_ready_o(b_ready),
        .axi_ar_valid_o(ar_valid), .axi_ar_ready_i(ar_ready), .axi_ar_o(ar),
        .axi_r_valid_i(r_valid), .axi_r_ready_o(r_ready), .axi_r_data_i(r_data)
    );

    function automatic logic [1:0] next_delay();
        logic [1:0] d;
        d = '0;
        for (int k = 0; k < 2; k++) begin
            d = {d[0], lfsr[0]}; // one step per bit
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return d;
    endfunction

    function automatic dword_t model_dword(addr_t a);
        dword_t v;
        for (int i = 0; i < 8; i++) v[8*i +: 8] = mem[8'(a + i)];
        return v;
    endfunction

    function automatic dword_t expect_load(addr_t a, int nbytes, logic uns);
        dword_t v;
        v = '0;
        for (int i = 0; i < nbytes; i++) v[8*i +: 8] = ref_mem[8'(a + i)];
        if (!uns && nbytes < 8 && v[8*nbytes-1]) v = v | (~64'h0 << (8 * nbytes));
        return v;
    endfunction

    initial begin
        for (int a = 0; a < 256; a++) begin
            ref_mem[a] = 8'(a * 8'h3b) ^ 8'ha7;
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int a = 0; a < 256; a++) begin
                mem[a] <= 8'(a * 8'h3b) ^ 8'ha7; // every address bit shows
            end
            ar_ready  <= 1'b0;
            aw_ready  <= 1'b0;
            w_ready   <= 1'b0;
            r_valid   <= 1'b0;
            r_data    <= '0;
            b_valid   <= 1'b0;
            aw_seen   <= 1'b0;
            w_seen    <= 1'b0;
            ar_wait   <= 2'd0;
            aw_wait   <= 2'd0;
            w_wait    <= 2'd0;
            txn_count <= 0;
        end else begin
            if (ar_valid && ar_ready) begin
                ar_ready <= 1'b0;
                ar_wait  <= next_delay();
                r_data   <= model_dword(ar.addr);
                r_valid  <= 1'b1;
                txn_count <= txn_count + 1;
            end else if (ar_valid) begin
                if (ar_wait == 0) ar_ready <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
            if (r_valid && r_ready) r_valid <= 1'b0;
            if (aw_valid && aw_ready) begin
                aw_ready <= 1'b0;
                aw_wait  <= next_delay();
                aw_seen  <= 1'b1;
                wr_addr  <= aw.addr;
            end else if (aw_valid) begin
                if (aw_wait == 0) aw_ready <= 1'b1;
                else aw_wait <= aw_wait - 1;
            end
            if (w_valid && w_ready) begin
                check("w last", 64'd1, 64'(w_last)); // single beat burst
                w_ready <= 1'b0;
                w_wait  <= next_delay();
                w_seen  <= 1'b1;
                wr_beat <= w;
            end else if (w_valid) begin
                if (w_wait == 0) w_ready <= 1'b1;
                else w_wait <= w_wait - 1;
            end
            if (aw_seen && w_seen) begin // both halves of the write arrived
                for (int i = 0; i < 8; i++) begin
                    if (wr_beat.strb[i]) mem[8'(wr_addr + i)] <= wr_beat.data[8*i +: 8];
                end
                aw_seen <= 1'b0;
                w_seen  <= 1'b0;
                b_valid <= 1'b1;
                txn_count <= txn_count + 1;
            end
            if (b_valid && b_ready) b_valid <= 1'b0;
        end
    end

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic check(input string name, input dword_t exp, input dword_t act);
        assert (exp === act) else begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("test %s passed", name);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", name, test_errs);
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    task automatic strobe_lsu(input logic we, input size_e size, input logic uns,
                              input addr_t a, input dword_t wd);
        @(posedge clk);
        lsu_req   <= 1'b1;
        lsu_we    <= we;
        lsu_size  <= size;
        lsu_uns   <= uns;
        lsu_addr  <= a;
        lsu_wdata <= wd;
    endtask

    task automatic lsu_access(input logic we, input size_e size, input logic uns,
                              input addr_t a, input dword_t wd, output dword_t rd);
        int n;
        strobe_lsu(we, size, uns, a, wd);
        @(posedge clk);
        lsu_req <= 1'b0;
        n = 0;
        while (!lsu_done && n < 100) begin
            @(posedge clk);
            n++;
            if (!lsu_done) check("lsu busy", 64'd1, 64'(lsu_busy));
        end
        if (!lsu_done) timeout_fail("load/store done");
        check("lsu busy at done", 64'd0, 64'(lsu_busy));
        rd = lsu_rdata;
        if (we) begin
            for (int i = 0; i < (1 << size); i++) ref_mem[8'(a + i)] = wd[8*i +: 8];
        end
    endtask

    task automatic fetch_word(input addr_t a, output instr_t ins);
        int n;
        @(posedge clk);
        fetch_req  <= 1'b1;
        fetch_addr <= a;
        @(posedge clk);
        fetch_req <= 1'b0;
        n = 0;
        while (!fetch_valid && n < 100) begin
            @(posedge clk);
            n++;
            if (!fetch_valid) check("fetch busy", 64'd1, 64'(fetch_busy));
        end
        if (!fetch_valid) timeout_fail("fetch valid");
        check("fetch busy at valid", 64'd0, 64'(fetch_busy));
        ins = fetch_instr;
    endtask

    task automatic store_then_check(input string name, input size_e size,
                                    input addr_t a, input dword_t wd);
        dword_t rd;
        lsu_access(1'b1, size, 1'b0, a, wd, rd);
        check({name, " store rdata"}, 64'h0, rd);
        lsu_access(1'b0, SIZE_D, 1'b0, {a[31:3], 3'b000}, '0, rd);
        check(name, expect_load({a[31:3], 3'b000}, 8, 1'b0), rd);
    endtask

    task automatic load_check(input string name, input size_e size, input logic uns,
                              input addr_t a);
        dword_t rd;
        lsu_access(1'b0, size, uns, a, '0, rd);
        check(name, expect_load(a, 1 << size, uns), rd);
    endtask

    initial begin
        instr_t ins;
        dword_t rd;
        int n, lsu_cyc, fetch_cyc, dones, txn0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        lsu_req    = 1'b0;
        lsu_we     = 1'b0;
        lsu_size   = SIZE_B;
        lsu_uns    = 1'b0;
        lsu_addr   = '0;
        lsu_wdata  = '0;
        n = 0;
        while (!arst_n && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (!arst_n) timeout_fail("reset release");

        fetch_word(32'h80, ins);
        check("fetch low", 64'(expect_load(32'h80, 4, 1'b1)), 64'(ins));
        fetch_word(32'h8c, ins);
        check("fetch high", 64'(expect_load(32'h8c, 4, 1'b1)), 64'(ins));
        end_test("fetch");

        store_then_check("store byte", SIZE_B, 32'h13, 64'h5a);
        store_then_check("store half", SIZE_H, 32'h22, 64'hbeef);
        store_then_check("store word", SIZE_W, 32'h34, 64'hcafe_f00d);
        store_then_check("store double", SIZE_D, 32'h48, 64'h0123_4567_89ab_cdef);
        end_test("stores");

        lsu_access(1'b1, SIZE_D, 1'b0, 32'h40, 64'h80f1_7f22_c3d4_e5b6, rd);
        load_check("lb neg", SIZE_B, 1'b0, 32'h40);
        load_check("lbu", SIZE_B, 1'b1, 32'h47);
        load_check("lb pos", SIZE_B, 1'b0, 32'h45);
        load_check("lh", SIZE_H, 1'b0, 32'h42);
        load_check("lhu", SIZE_H, 1'b1, 32'h46);
        load_check("lw", SIZE_W, 1'b0, 32'h40);
        load_check("lwu", SIZE_W, 1'b1, 32'h44);
        end_test("loads");

        strobe_lsu(1'b0, SIZE_D, 1'b0, 32'h40, '0);
        fetch_req <= 1'b1;
        fetch_addr <= 32'h84;
        @(posedge clk);
        lsu_req <= 1'b0;
        fetch_req <= 1'b0;
        n = 0;
        lsu_cyc = -1;
        fetch_cyc = -1;
        while ((lsu_cyc < 0 || fetch_cyc < 0) && n < 200) begin
            @(posedge clk);
            if (lsu_done) begin
                lsu_cyc = n;
                check("both lsu data", expect_load(32'h40, 8, 1'b0), lsu_rdata);
            end
            if (fetch_valid) begin
                fetch_cyc = n;
                check("both fetch data", 64'(expect_load(32'h84, 4, 1'b1)), 64'(fetch_instr));
            end
            n++;
        end
        if (lsu_cyc < 0 || fetch_cyc < 0) timeout_fail("both ports");
        check("lsu done first", 64'd1, 64'(lsu_cyc < fetch_cyc));
        end_test("contention");

        txn0 = txn_count;
        strobe_lsu(1'b1, SIZE_B, 1'b0, 32'h61, 64'h3c);
        @(posedge clk);
        lsu_wdata <= 64'hc3; // second strobe while busy
        @(posedge clk);
        lsu_req <= 1'b0;
        dones = 0;
        for (int c = 0; c < 40; c++) begin
            @(posedge clk);
            if (lsu_done) dones++;
        end
        ref_mem[8'h61] = 8'h3c;
        check("busy dones", 64'd1, 64'(dones));
        check("busy txns", 64'd1, 64'(txn_count - txn0));
        lsu_access(1'b0, SIZE_D, 1'b0, 32'h60, '0, rd);
        check("busy memory", expect_load(32'h60, 8, 1'b0), rd);
        end_test("busy strobe");

        total_errs += cpu_mem_top_inst.cpu_mem_properties_inst.assert_errs;
        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, total_errs);
        if (total_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== cpu_mem_top.f ====
+incdir+.
mem_pkg.sv
fetch_port.sv
lsu_port.sv
mem_arbiter.sv
axi_master.sv
cpu_mem_top.sv
tb_clock.sv
cpu_mem_properties.sv
tb_cpu_mem_top.sv

// ==== Makefile ====
TOP := tb_cpu_mem_top

.PHONY: help test clean

help:
	@echo "targets: test (build and run with Verilator), clean, help"

test:
	verilator --binary --timing --assert -f cpu_mem_top.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q '^\*\* PASS \*\*$$'

clean:
	rm -rf obj_dir
